// ==== Bender.yml ====
package:
  name: writeback

sources:
  - rtl/wbPkg.sv
  - rtl/layerSum.sv
  - rtl/bytePacker.sv
  - rtl/bramWriter.sv
  - rtl/writeback.sv
  - target: simulation
    files:
      - sim/writebackTb.sv

// ==== all.f ====
rtl/wbPkg.sv
rtl/layerSum.sv
rtl/bytePacker.sv
rtl/bramWriter.sv
rtl/writeback.sv
sim/writebackTb.sv

// ==== rtl/bramWriter.sv ====
////////////////////
// one write per word; addresses step after the write cycle
// finishRow jumps both ports by RowStride, wraps at 4k entries
////////////////////
`timescale 1ns/1ps

module bramWriter
    import wbPkg::*;
#(
    parameter int RowStride = 128,
    parameter int PortBBase = 128
) (
    input  logic     clk,
    input  logic     rst,
    input  wordPairT word,
    input  logic     wordValid,
    input  logic     finishRow,
    output bramWrT   bram
);

    addrT step;

    // write increment plus optional row jump
    always_comb begin
        step = addrT'(bram.we);
        if (finishRow) begin
            step = step + addrT'(RowStride);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bram.we <= 1'b0;
            bram.dinA <= '0;
            bram.dinB <= '0;
        end else begin
            bram.we <= wordValid;
            if (wordValid) begin
                bram.dinA <= word.a;
                bram.dinB <= word.b;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bram.addrA <= '0;
            bram.addrB <= addrT'(PortBBase);
        end else begin
            bram.addrA <= bram.addrA + step;
            bram.addrB <= bram.addrB + step;
        end
    end

    weSingle: assert property (
        @(posedge clk) disable iff (!rst)
        bram.we |=> !bram.we
    ) else $error("we held for two cycles");

endmodule

// ==== rtl/bytePacker.sv ====
////////////////////
// eight bytes per word, a gap in pixValid drops the partial word
////////////////////
`timescale 1ns/1ps

module bytePacker
    import wbPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  pixelPairT pix,
    input  logic      pixValid,
    output wordPairT  word,
    output logic      wordValid
);

    localparam int CntW  = $clog2(BytesPerWord);
    localparam int KeepW = $bits(wordT) - $bits(pixelT);

    logic [CntW-1:0] byteCnt;
    wordT            shiftA;
    wordT            shiftB;
    wordT            nextA;
    wordT            nextB;
    logic            lastByte;

    // new byte enters at the bottom, so the first one ends up on top
    assign nextA    = {shiftA[KeepW-1:0], pix.a};
    assign nextB    = {shiftB[KeepW-1:0], pix.b};
    assign lastByte = (byteCnt == CntW'(BytesPerWord - 1));

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            byteCnt <= '0;
            shiftA  <= '0;
            shiftB  <= '0;
        end else if (pixValid) begin
            shiftA  <= nextA;
            shiftB  <= nextB;
            byteCnt <= lastByte ? '0 : byteCnt + 1'b1;
        end else begin
            byteCnt <= '0;  // gap discards unfinished bytes
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            word      <= '0;
            wordValid <= 1'b0;
        end else begin
            wordValid <= pixValid && lastByte;
            if (pixValid && lastByte) begin
                word.a <= nextA;
                word.b <= nextB;
            end
        end
    end

    // at most one word per eight pixels
    wordSingle: assert property (
        @(posedge clk) disable iff (!rst)
        wordValid |=> !wordValid
    ) else $error("wordValid high on consecutive cycles");

endmodule

// ==== rtl/layerSum.sv ====
////////////////////
// two-stage sum, shift and clamp, no back-pressure
////////////////////
`timescale 1ns/1ps

module layerSum
    import wbPkg::*;
#(
    parameter int ScaleShift = 9
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      wbEn,
    input  psumSetT   sumsA,
    input  psumSetT   sumsB,
    output pixelPairT pix,
    output logic      pixValid
);

    accT  accA;
    accT  accB;
    logic accValid;

    // signed sum of all terms, then arithmetic scale
    function automatic accT laneSum(psumSetT s);
        accT total;
        total = '0;
        for (int i = 0; i < NumTerms; i++) begin
            total = total + accT'(s.term[i]);
        end
        return total >>> ScaleShift;
    endfunction

    // clamp to a signed byte
    function automatic pixelT clampByte(accT v);
        pixelT res;
        if (v > AccMax) begin
            res = PixMax;
        end else if (v < AccMin) begin
            res = PixMin;
        end else begin
            res = pixelT'(v[7:0]);
        end
        return res;
    endfunction

    // stage one
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            accA     <= '0;
            accB     <= '0;
            accValid <= 1'b0;
        end else begin
            accValid <= wbEn;
            if (wbEn) begin
                accA <= laneSum(sumsA);
                accB <= laneSum(sumsB);
            end
        end
    end

    // stage two
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            pix      <= '0;
            pixValid <= 1'b0;
        end else begin
            pixValid <= accValid;
            if (accValid) begin
                pix.a <= clampByte(accA);
                pix.b <= clampByte(accB);
            end
        end
    end

    // a sample two cycles back must come out as a known pixel
    pixKnown: assert property (
        @(posedge clk) disable iff (!rst)
        pixValid |-> !$isunknown(pix)
    ) else $error("pix unknown while pixValid");

endmodule

// ==== rtl/wbPkg.sv ====
////////////////////
// shared types of the write-back stage, first layer only
// pixel bytes are signed, packed first byte highest
////////////////////
package wbPkg;

    typedef logic signed [18:0] psumT;  // one PE partial sum
    typedef logic signed [21:0] accT;   // five-term total
    typedef logic signed [7:0]  pixelT;
    typedef logic [63:0]        wordT;
    typedef logic [11:0]        addrT;

    localparam int NumTerms     = 5;
    localparam int BytesPerWord = 8;

    // saturation bounds
    localparam accT   AccMax = 22'sd127;
    localparam accT   AccMin = -22'sd128;
    localparam pixelT PixMax = 8'sh7f;
    localparam pixelT PixMin = 8'sh80;

    typedef struct packed {
        psumT [NumTerms-1:0] term;
    } psumSetT;

    typedef struct packed {
        pixelT a;
        pixelT b;
    } pixelPairT;

    typedef struct packed {
        wordT a;
        wordT b;
    } wordPairT;

    typedef struct packed {
        logic we;
        addrT addrA;
        addrT addrB;  // port B runs above port A
        wordT dinA;
        wordT dinB;
    } bramWrT;

endpackage

// ==== rtl/writeback.sv ====
////////////////////
// write-back top, first layer path only
// eighth sample at edge t gives we at t+4
////////////////////
`timescale 1ns/1ps

module writeback
    import wbPkg::*;
#(
    parameter int ScaleShift = 9,
    parameter int RowStride  = 128,
    parameter int PortBBase  = 128
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    wbEn,
    input  logic    finishRow,
    input  psumSetT sumsA,
    input  psumSetT sumsB,
    output bramWrT  bram
);

    pixelPairT pix;
    logic      pixValid;
    wordPairT  word;
    logic      wordValid;

    layerSum #(
        .ScaleShift (ScaleShift)
    ) u_layerSum (
        .clk      (clk),
        .rst      (rst),
        .wbEn     (wbEn),
        .sumsA    (sumsA),
        .sumsB    (sumsB),
        .pix      (pix),
        .pixValid (pixValid)
    );

    bytePacker u_bytePacker (
        .clk       (clk),
        .rst       (rst),
        .pix       (pix),
        .pixValid  (pixValid),
        .word      (word),
        .wordValid (wordValid)
    );

    // finishRow skips the pipeline
    bramWriter #(
        .RowStride (RowStride),
        .PortBBase (PortBBase)
    ) u_bramWriter (
        .clk       (clk),
        .rst       (rst),
        .word      (word),
        .wordValid (wordValid),
        .finishRow (finishRow),
        .bram      (bram)
    );

endmodule

// ==== sim/writebackTb.sv ====
////////////////////
// directed tests, stops at the first mismatch
// writes are sampled on the falling edge
////////////////////
`timescale 1ns/1ps

module writebackTb
    import wbPkg::*;
();

    localparam int ClkPeriod  = 40;
    localparam int ScaleShift = 9;
    localparam int RowStride  = 128;
    localparam int PortBBase  = 128;

    // cycle budget: reset, then each test with its wait limit and settle time
    localparam int WaitLimit    = 64;
    localparam int SettleCycles = 12;
    localparam int WordCycles   = BytesPerWord + WaitLimit + SettleCycles;
    localparam int BudgetCycles = 8 + 2 + 2 * WordCycles + (24 + WaitLimit + SettleCycles)
                                  + (6 + WordCycles) + (2 + WordCycles);
    localparam int MarginCycles = 100;

    typedef struct packed {
        logic [31:0] cycle;  // edge that samples we high
        bramWrT      wr;
    } writeRecT;

    logic    clk;
    logic    rst;
    logic    wbEn;
    logic    finishRow;
    psumSetT sumsA;
    psumSetT sumsB;
    bramWrT  bram;

    int          cycleCnt;
    logic [31:0] rngState;
    addrT        expAddrA;
    addrT        expAddrB;

    psumSetT  sentA[$];
    psumSetT  sentB[$];
    int       acceptEdge[$];
    writeRecT caps[$];

    writeback #(
        .ScaleShift (ScaleShift),
        .RowStride  (RowStride),
        .PortBBase  (PortBBase)
    ) u_writeback (
        .clk       (clk),
        .rst       (rst),
        .wbEn      (wbEn),
        .finishRow (finishRow),
        .sumsA     (sumsA),
        .sumsB     (sumsB),
        .bram      (bram)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    always @(posedge clk) cycleCnt <= cycleCnt + 1;

    // record every write cycle
    always @(negedge clk) begin
        if (rst && bram.we) begin
            caps.push_back(writeRecT'({cycleCnt + 1, bram}));
        end
    end

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic psumSetT makeSet(int t0, int t1, int t2, int t3, int t4);
        psumSetT s;
        s.term[0] = psumT'(t0);
        s.term[1] = psumT'(t1);
        s.term[2] = psumT'(t2);
        s.term[3] = psumT'(t3);
        s.term[4] = psumT'(t4);
        return s;
    endfunction

    // terms within +-12800 keep the scaled sum inside a byte
    function automatic psumSetT randomSet();
        psumSetT s;
        for (int i = 0; i < NumTerms; i++) begin
            rngState  = xorshift32(rngState);
            s.term[i] = psumT'(int'(rngState % 25601) - 12800);
        end
        return s;
    endfunction

    // sum, arithmetic shift, clamp
    function automatic logic [7:0] pixelModel(psumSetT s);
        int total;
        int scaled;
        total = 0;
        for (int i = 0; i < NumTerms; i++) begin
            total = total + int'(s.term[i]);
        end
        scaled = total >>> ScaleShift;
        if (scaled > 127) begin
            return 8'h7f;
        end else if (scaled < -128) begin
            return 8'h80;
        end
        return scaled[7:0];
    endfunction

    function automatic wordT packBytes(int first, bit laneB);
        wordT w;
        w = '0;
        for (int i = 0; i < BytesPerWord; i++) begin
            w = {w[55:0], laneB ? pixelModel(sentB[first + i]) : pixelModel(sentA[first + i])};
        end
        return w;
    endfunction

    task automatic abortRun();
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compareValue(string name, logic [63:0] exp, logic [63:0] act);
        assert (act === exp) else begin
            $display("** Error: %s expected 0x%h, actual 0x%h", name, exp, act);
            abortRun();
        end
    endtask

    task automatic clearRecords();
        sentA.delete();
        sentB.delete();
        acceptEdge.delete();
        caps.delete();
    endtask

    task automatic driveSample(psumSetT a, psumSetT b);
        @(negedge clk);
        wbEn  = 1'b1;
        sumsA = a;
        sumsB = b;
        sentA.push_back(a);
        sentB.push_back(b);
        acceptEdge.push_back(cycleCnt + 1);
    endtask

    task automatic idleCycle();
        @(negedge clk);
        wbEn  = 1'b0;
        sumsA = '0;
        sumsB = '0;
    endtask

    // wait for n writes, then make sure no extra write follows
    task automatic awaitWrites(int n);
        int waited;
        waited = 0;
        while (caps.size() < n && waited < WaitLimit) begin
            @(negedge clk);
            waited++;
        end
        if (caps.size() < n) begin
            $display("timed out waiting for a BRAM write");
            abortRun();
        end
        repeat (SettleCycles) @(negedge clk);
        compareValue("write count", n, caps.size());
    endtask

    task automatic verifyWords(int first, int nWords);
        int       idx;
        writeRecT rec;
        awaitWrites(nWords);
        for (int k = 0; k < nWords; k++) begin
            idx = first + k * BytesPerWord;
            rec = caps[k];
            compareValue("we edge", acceptEdge[idx + BytesPerWord - 1] + 4, rec.cycle);
            compareValue("bram.addrA", expAddrA, rec.wr.addrA);
            compareValue("bram.addrB", expAddrB, rec.wr.addrB);
            compareValue("bram.dinA", packBytes(idx, 1'b0), rec.wr.dinA);
            compareValue("bram.dinB", packBytes(idx, 1'b1), rec.wr.dinB);
            expAddrA++;
            expAddrB++;
        end
    endtask

    task automatic resetDefaults();
        @(negedge clk);
        compareValue("bram.we", 0, bram.we);
        compareValue("bram.addrA", 0, bram.addrA);
        compareValue("bram.addrB", PortBBase, bram.addrB);
    endtask

    task automatic packOneWord();
        clearRecords();
        repeat (BytesPerWord) driveSample(randomSet(), randomSet());
        idleCycle();
        verifyWords(0, 1);
    endtask

    task automatic saturateBytes();
        int vals[8] = '{65024, -65536, 65536, -65537, 262143, -262144, 511, -1};
        clearRecords();
        for (int i = 0; i < BytesPerWord; i++) begin
            driveSample(vals[i] == 262143 || vals[i] == -262144 ?
                            makeSet(vals[i], vals[i], vals[i], vals[i], vals[i]) :
                            makeSet(vals[i], 0, 0, 0, 0),
                        makeSet(vals[7 - i], 0, 0, 0, 0));
        end
        idleCycle();
        verifyWords(0, 1);
        compareValue("bram.dinA", 64'h7f807f807f8000ff, caps[0].wr.dinA);
        compareValue("bram.dinB", 64'hff00807f807f807f, caps[0].wr.dinB);
    endtask

    task automatic streamWords();
        clearRecords();
        repeat (3 * BytesPerWord) driveSample(randomSet(), randomSet());
        idleCycle();
        verifyWords(0, 3);
    endtask

    task automatic gapDiscard();
        clearRecords();
        repeat (5) driveSample(randomSet(), randomSet());
        idleCycle();
        repeat (BytesPerWord) driveSample(randomSet(), randomSet());
        idleCycle();
        verifyWords(5, 1);
    endtask

    task automatic rowJump();
        clearRecords();
        @(negedge clk);
        finishRow = 1'b1;
        @(negedge clk);
        finishRow = 1'b0;
        expAddrA  = expAddrA + addrT'(RowStride);
        expAddrB  = expAddrB + addrT'(RowStride);
        compareValue("bram.addrA", expAddrA, bram.addrA);
        compareValue("bram.addrB", expAddrB, bram.addrB);
        repeat (BytesPerWord) driveSample(randomSet(), randomSet());
        idleCycle();
        verifyWords(0, 1);
    endtask

    initial begin
        #(ClkPeriod * (BudgetCycles + MarginCycles));
        $display("watchdog expired, the run did not finish in time");
        abortRun();
    end

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        wbEn      = 1'b0;
        finishRow = 1'b0;
        sumsA     = '0;
        sumsB     = '0;
        cycleCnt  = 0;
        rngState  = 32'hce6;
        expAddrA  = '0;
        expAddrB  = addrT'(PortBBase);
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;

        resetDefaults();
        packOneWord();
        saturateBytes();
        streamWords();
        gapDiscard();
        rowJump();

        $display("Test completed successfully");
        $finish;
    end

endmodule
